// ==== Makefile ====
TOP = mem_seq_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f mem_seq_top.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert -f mem_seq_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== access_if.sv ====
// Lane plan of the access in flight, shared by the address generator, the
// state machine and the load merger. The FSM drives the beat-one capture strobe.
interface access_if;

	// Beats, split flag and byte offset of the current access
	apb_pkg::lane_plan_t lanes;

	// Size and sign of a load, needed only for the final extension
	mem_req_pkg::mem_size_e size;
	logic is_signed;

	// High in the cycle where beat one of a load completes
	logic capture;

	// The address generator builds the plan once per request
	modport plan_src (output lanes, output size, output is_signed);

	// The FSM walks the beats and marks when beat one's data is on the bus
	modport plan_use (input lanes, output capture);

	// The merger needs the whole plan plus the capture strobe
	modport merge_use (input lanes, input size, input is_signed, input capture);

endinterface

// ==== apb_pkg.sv ====
// Types for the APB side of the sequencer: a single planned beat, the lane
// plan of a whole access and the counter type of the wait timer.
`include "mem_seq_macros.svh"

package apb_pkg;

	// One APB transfer, with the address already aligned to a 64-bit word
	typedef struct packed {
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_STRB_W-1:0] strb;
		logic [`MEM_DATA_W-1:0] wdata;
	} apb_beat_t;

	// Everything the sequencer needs to run and merge one access
	// beat1 is only meaningful when two_beat is set
	typedef struct packed {
		apb_beat_t  beat0;
		apb_beat_t  beat1;
		logic       two_beat;
		logic [2:0] offset;
	} lane_plan_t;

	// Counts access-phase wait cycles up to the limit
	typedef logic [$clog2(`MEM_WAIT_LIMIT)-1:0] apb_wait_t;

endpackage

// ==== load_merge.sv ====
// Load merger. Keeps the first beat of a split load, joins it with the live
// second beat, then shifts the addressed bytes down and extends them.
`include "mem_seq_macros.svh"

module load_merge import mem_req_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`MEM_DATA_W-1:0] prdata_i,
	output logic [`MEM_DATA_W-1:0] rdata_o,
	access_if.merge_use            merge
);

	logic [`MEM_DATA_W-1:0]   beat0_q;
	logic [`MEM_DATA_W-1:0]   low_word;
	logic [2*`MEM_DATA_W-1:0] span;
	logic [2*`MEM_DATA_W-1:0] shifted;
	logic [`MEM_DATA_W-1:0]   value;

	// Beat one's read data is only on prdata for its completing cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			beat0_q <= '0;
		end else if (merge.capture) begin
			beat0_q <= prdata_i;
		end
	end

	// ==================================================
	// Merge then align
	// ==================================================

	// A single-beat load has all its bytes in the live word
	assign low_word = merge.lanes.two_beat ? beat0_q : prdata_i;

	// Second word above the first, as the bytes lie in memory
	assign span    = {prdata_i, low_word};
	assign shifted = span >> {merge.lanes.offset, 3'b000};
	assign value   = shifted[`MEM_DATA_W-1:0];

	// Keep size bytes and fill the rest with zeros or copies of the top bit
	always_comb begin
		case (merge.size)
			size_byte: begin
				rdata_o = {{56{merge.is_signed & value[7]}}, value[7:0]};
			end
			size_half: begin
				rdata_o = {{48{merge.is_signed & value[15]}}, value[15:0]};
			end
			size_word: begin
				rdata_o = {{32{merge.is_signed & value[31]}}, value[31:0]};
			end
			default: begin
				rdata_o = value;
			end
		endcase
	end

endmodule

// ==== mem_agen.sv ====
// Address generator. Turns an accepted request into one or two word beats
// with byte strobes and shifted store data, and holds them for the access.
`include "mem_seq_macros.svh"

module mem_agen import mem_req_pkg::*, apb_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  mem_req_t   req_i,
	input  logic       load_i,
	access_if.plan_src plan
);

	logic [2:0]                 offset;
	logic [3:0]                 nbytes;
	logic [`MEM_STRB_W-1:0]     size_mask;
	logic [2*`MEM_STRB_W-1:0]   span_strb;
	logic [2*`MEM_DATA_W-1:0]   span_data;
	logic [`MEM_ADDR_W-1:0]     word_addr;
	logic                       two_beat_d;
	apb_beat_t                  beat0_q;
	apb_beat_t                  beat1_q;
	logic                       two_beat_q;
	logic [2:0]                 offset_q;
	mem_size_e                  size_q;
	logic                       signed_q;

	// Byte position inside the 64-bit word
	assign offset = req_i.addr[2:0];
	assign nbytes = 4'd1 << req_i.size;

	// The access spills into the next word when it runs past byte 7
	assign two_beat_d = ({1'b0, offset} + nbytes) > 4'd8;

	// Lanes touched by an aligned access of this size
	always_comb begin
		case (req_i.size)
			size_byte:   size_mask = 8'h01;
			size_half:   size_mask = 8'h03;
			size_word:   size_mask = 8'h0f;
			default:     size_mask = 8'hff;
		endcase
	end

	// Shift lanes and data across two words, the upper half becomes beat two
	assign span_strb = {{`MEM_STRB_W{1'b0}}, size_mask} << offset;
	assign span_data = {{`MEM_DATA_W{1'b0}}, req_i.wdata} << {offset, 3'b000};
	assign word_addr = {req_i.addr[`MEM_ADDR_W-1:3], 3'b000};

	// ==================================================
	// Plan registers
	// ==================================================

	// Control part of the plan
	always_ff @(posedge clk) begin
		if (rst) begin
			two_beat_q <= 1'b0;
			offset_q   <= 3'd0;
			size_q     <= size_byte;
			signed_q   <= 1'b0;
		end else if (load_i) begin
			two_beat_q <= two_beat_d;
			offset_q   <= offset;
			size_q     <= req_i.size;
			signed_q   <= req_i.is_signed;
		end
	end

	// Beat payload, only looked at once the FSM has left idle
	always_ff @(posedge clk) begin
		if (load_i) begin
			beat0_q.addr  <= word_addr;
			beat0_q.strb  <= span_strb[`MEM_STRB_W-1:0];
			beat0_q.wdata <= span_data[`MEM_DATA_W-1:0];
			beat1_q.addr  <= word_addr + 8;
			beat1_q.strb  <= span_strb[2*`MEM_STRB_W-1:`MEM_STRB_W];
			beat1_q.wdata <= span_data[2*`MEM_DATA_W-1:`MEM_DATA_W];
		end
	end

	assign plan.lanes     = '{beat0: beat0_q, beat1: beat1_q, two_beat: two_beat_q,
		offset: offset_q};
	assign plan.size      = size_q;
	assign plan.is_signed = signed_q;

endmodule

// ==== mem_req_pkg.sv ====
// Types for the processor side of the sequencer: one load or store request
// and the response returned when the access has finished.
`include "mem_seq_macros.svh"

package mem_req_pkg;

	// ==================================================
	// Request
	// ==================================================

	// Access size, the encoding is log2 of the byte count
	typedef enum logic [1:0] {
		size_byte   = 2'd0,
		size_half   = 2'd1,
		size_word   = 2'd2,
		size_double = 2'd3
	} mem_size_e;

	// One memory request as the core hands it over
	// The store data sits in the low bytes, unaligned to the address
	typedef struct packed {
		logic                   store;
		mem_size_e              size;
		logic                   is_signed;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata;
		logic [`MEM_TAG_W-1:0]  tag;
	} mem_req_t;

	// ==================================================
	// Response
	// ==================================================

	// Completion status of an access
	typedef enum logic [1:0] {
		err_none    = 2'd0,
		err_slave   = 2'd1,
		err_timeout = 2'd2
	} mem_err_e;

	// Load data is already aligned and extended to the full width
	typedef struct packed {
		logic [`MEM_TAG_W-1:0]  tag;
		logic [`MEM_DATA_W-1:0] rdata;
		logic                   store;
		mem_err_e               err;
	} mem_rsp_t;

endpackage

// ==== mem_seq_fsm.sv ====
// Sequencer FSM. Accepts one request, runs its one or two APB beats, watches
// for slave errors and timeouts, and issues a single response pulse.
`include "mem_seq_macros.svh"

module mem_seq_fsm import mem_req_pkg::*, apb_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid_i,
	output logic                   req_ready_o,
	input  mem_req_t               req_i,
	output logic                   rsp_valid_o,
	output mem_rsp_t               rsp_o,
	output logic                   psel_o,
	output logic                   penable_o,
	output logic                   pwrite_o,
	output logic [`MEM_ADDR_W-1:0] paddr_o,
	output logic [`MEM_DATA_W-1:0] pwdata_o,
	output logic [`MEM_STRB_W-1:0] pstrb_o,
	input  logic                   pready_i,
	input  logic                   pslverr_i,
	input  logic [`MEM_DATA_W-1:0] rdata_i,
	output logic                   load_o,
	output logic                   timer_run_o,
	input  logic                   timer_expired_i,
	access_if.plan_use             plan
);

	typedef enum logic [2:0] {
		st_idle, st_setup1, st_access1, st_setup2, st_access2, st_respond
	} state_e;

	state_e    state_q;
	state_e    state_d;
	apb_beat_t beat;
	logic      second;
	logic      in_access;
	logic      last_beat;
	mem_rsp_t  rsp_q;

	// Decode of the current phase
	assign second    = (state_q == st_setup2) || (state_q == st_access2);
	assign in_access = (state_q == st_access1) || (state_q == st_access2);
	assign last_beat = second || !plan.lanes.two_beat;

	// ==================================================
	// Next state
	// ==================================================

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (req_valid_i) state_d = st_setup1;
			end
			st_setup1: state_d = st_access1;
			st_access1: begin
				// A slave error ends the access here, no second beat
				if (pready_i) begin
					state_d = (pslverr_i || !plan.lanes.two_beat) ? st_respond : st_setup2;
				end else if (timer_expired_i) begin
					state_d = st_respond;
				end
			end
			st_setup2: state_d = st_access2;
			st_access2: begin
				if (pready_i || timer_expired_i) state_d = st_respond;
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// Response is built up over the access and held for the RESPOND cycle
	always_ff @(posedge clk) begin
		if (load_o) begin
			rsp_q.tag   <= req_i.tag;
			rsp_q.store <= req_i.store;
			rsp_q.err   <= err_none;
			rsp_q.rdata <= '0;
		end else if (in_access) begin
			if (pready_i && pslverr_i) begin
				rsp_q.err <= err_slave;
			end else if (pready_i && last_beat && !rsp_q.store) begin
				rsp_q.rdata <= rdata_i;
			end else if (!pready_i && timer_expired_i) begin
				rsp_q.err <= err_timeout;
			end
		end
	end

	// ==================================================
	// Outputs
	// ==================================================

	assign req_ready_o = (state_q == st_idle);
	assign load_o      = req_valid_i && req_ready_o;

	// APB lines follow the beat of the current state and hold through the access
	assign beat      = second ? plan.lanes.beat1 : plan.lanes.beat0;
	assign psel_o    = (state_q == st_setup1) || (state_q == st_setup2) || in_access;
	assign penable_o = in_access;
	assign pwrite_o  = rsp_q.store;
	assign paddr_o   = beat.addr;
	assign pwdata_o  = beat.wdata;
	assign pstrb_o   = rsp_q.store ? beat.strb : '0;

	// Beat one of a load is on prdata only in its completing cycle
	assign plan.capture = (state_q == st_access1) && pready_i && !pslverr_i && !rsp_q.store;
	assign timer_run_o  = in_access;

	assign rsp_valid_o = (state_q == st_respond);
	assign rsp_o       = rsp_q;

endmodule

// ==== mem_seq_macros.svh ====
// Bus widths, register tag width and the wait-timer limit of the memory sequencer.
// Include this header wherever a width or the timeout limit is needed.
`ifndef MEM_SEQ_MACROS_SVH
`define MEM_SEQ_MACROS_SVH

// ==================================================
// Bus geometry
// ==================================================

// Width of the APB data bus and of one load result
`define MEM_DATA_W 64

// Byte address width of a request and of paddr
`define MEM_ADDR_W 32

// One strobe bit per byte lane of the data bus
`define MEM_STRB_W (`MEM_DATA_W / 8)

// Destination register tag carried from request to response
`define MEM_TAG_W 6

// Access-phase cycles with pready low after which a beat is abandoned
`define MEM_WAIT_LIMIT 16

`endif

// ==== mem_seq_props.sv ====
// APB and response assertions for the memory sequencer.
// Bound to mem_seq_top from this file, so the testbench needs no extra wiring.
`include "mem_seq_macros.svh"

module mem_seq_props (
	input logic                   clk,
	input logic                   rst,
	input logic                   psel_i,
	input logic                   penable_i,
	input logic                   pwrite_i,
	input logic [`MEM_ADDR_W-1:0] paddr_i,
	input logic [`MEM_DATA_W-1:0] pwdata_i,
	input logic [`MEM_STRB_W-1:0] pstrb_i,
	input logic                   pready_i,
	input logic                   rsp_valid_i,
	input logic                   req_ready_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// Access phase never runs without a selected slave
	penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
		penable_i |-> psel_i) else $error("penable high without psel");

	// Transfer lines hold from setup until the beat completes
	lines_stable: assert property (@(posedge clk) disable iff (rst)
		(psel_i && !(penable_i && pready_i)) ##1 psel_i
		|-> $stable({paddr_i, pwrite_i, pwdata_i, pstrb_i}))
		else $error("APB lines changed before pready");

	// Response is a single-cycle pulse
	rsp_single_pulse: assert property (@(posedge clk) disable iff (rst)
		rsp_valid_i |=> !rsp_valid_i) else $error("rsp_valid held longer than one cycle");

	// No new request while a transfer is on the bus
	no_ready_in_transfer: assert property (@(posedge clk) disable iff (rst)
		psel_i |-> !req_ready_i) else $error("req_ready high during a transfer");

endmodule

bind mem_seq_top mem_seq_props u_props (
	.clk         (clk),
	.rst         (rst),
	.psel_i      (psel_o),
	.penable_i   (penable_o),
	.pwrite_i    (pwrite_o),
	.paddr_i     (paddr_o),
	.pwdata_i    (pwdata_o),
	.pstrb_i     (pstrb_o),
	.pready_i    (pready_i),
	.rsp_valid_i (rsp_valid_o),
	.req_ready_i (req_ready_o)
);

// ==== mem_seq_tb.sv ====
// Testbench for the memory sequencer. Drives seeded random loads and stores,
// answers them from an APB memory model and checks beats and responses.
`include "mem_seq_macros.svh"

module mem_seq_tb import mem_req_pkg::*, apb_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_REQ     = 400;
	localparam int CYCLE_LIMIT = NUM_REQ * (2 * (`MEM_WAIT_LIMIT + 6)) + 50;

	logic                   clk;
	logic                   rst;
	logic                   req_valid;
	logic                   req_ready;
	mem_req_t               req;
	logic                   rsp_valid;
	mem_rsp_t               rsp;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`MEM_ADDR_W-1:0] paddr;
	logic [`MEM_DATA_W-1:0] pwdata;
	logic [`MEM_STRB_W-1:0] pstrb;
	logic [`MEM_DATA_W-1:0] prdata;
	logic                   pready;
	logic                   pslverr;

	// Slave memory and the reference copy, 256 words of 8 bytes each
	logic [7:0] mem [0:2047];
	logic [7:0] ref_mem [0:2047];
	apb_beat_t  exp_beats[$];
	logic       exp_write;
	int         wait_left;
	int         cycles;
	int         rsp_count;

	mem_seq_top DUT (
		.clk(clk), .rst(rst), .req_valid_i(req_valid), .req_ready_o(req_ready),
		.req_i(req), .rsp_valid_o(rsp_valid), .rsp_o(rsp), .psel_o(psel),
		.penable_o(penable), .pwrite_o(pwrite), .paddr_o(paddr), .pwdata_o(pwdata),
		.pstrb_o(pstrb), .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr)
	);

	always #50 clk = ~clk;

	// ==================================================
	// Reporting
	// ==================================================

	task automatic report_failure(input string msg);
		$display("%s, at time %0t", msg, $time);
		$display("TESTS FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp);
		if (got !== exp) begin
			$display("Error at %0t: response tag %0d err %s data %h store %b",
				$time, got.tag, got.err.name(), got.rdata, got.store);
			$display("  expected tag %0d err %s data %h store %b",
				exp.tag, exp.err.name(), exp.rdata, exp.store);
			$display("TESTS FAILED");
			$fatal(1, "Response mismatch");
		end
	endtask

	task automatic check_beat(input apb_beat_t got, input apb_beat_t exp);
		if (got !== exp) begin
			$display("Error at %0t: beat addr %h strb %b data %h",
				$time, got.addr, got.strb, got.wdata);
			$display("  expected addr %h strb %b data %h", exp.addr, exp.strb, exp.wdata);
			$display("TESTS FAILED");
			$fatal(1, "APB beat mismatch");
		end
	endtask

	task automatic check_write(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: pwrite %b, expected %b", $time, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "APB direction mismatch");
		end
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	// Fill value mixes low and high address bits
	function automatic logic [7:0] fill_byte(input int a);
		return 8'((a * 37) ^ (a >> 5) ^ 8'h5a);
	endfunction

	// Memory map of the slave model
	function automatic mem_err_e region_status(input logic [31:0] w);
		if (w >= 32'h1000) return err_timeout;
		if (w[11]) return err_slave;
		return err_none;
	endfunction

	// Queues the expected beats, updates the reference copy and forms the response
	task automatic predict(input mem_req_t r, output mem_rsp_t e);
		apb_beat_t  bt [2];
		int         n;
		int         off;
		int         pos;
		int         nbeats;
		logic [63:0] val;
		n = 1 << r.size;
		off = r.addr[2:0];
		nbeats = (off + n > 8) ? 2 : 1;
		for (int b = 0; b < 2; b++) begin
			bt[b].addr  = {r.addr[31:3], 3'b000} + 32'(8 * b);
			bt[b].strb  = '0;
			bt[b].wdata = '0;
		end
		// Byte j of the store data goes to address addr + j
		for (int j = 0; j < 8; j++) begin
			pos = off + j;
			bt[pos / 8].wdata[(pos % 8) * 8 +: 8] = r.wdata[j * 8 +: 8];
			if (j < n && r.store) bt[pos / 8].strb[pos % 8] = 1'b1;
		end
		e.tag = r.tag;
		e.store = r.store;
		e.err = err_none;
		e.rdata = '0;
		for (int b = 0; b < nbeats; b++) begin
			exp_beats.push_back(bt[b]);
			e.err = region_status(bt[b].addr);
			if (e.err != err_none) break;
			for (int l = 0; l < 8; l++) begin
				if (bt[b].strb[l]) ref_mem[bt[b].addr[10:0] + l] = bt[b].wdata[l * 8 +: 8];
			end
		end
		if (!r.store && e.err == err_none) begin
			val = '0;
			for (int j = 0; j < n; j++) val[j * 8 +: 8] = ref_mem[(r.addr + j) % 2048];
			if (r.is_signed && n < 8 && val[n * 8 - 1]) val = val | ({64{1'b1}} << (n * 8));
			e.rdata = val;
		end
	endtask

	// Mostly plain memory, with some error-region and non-responding accesses
	task automatic make_request(input int k, output mem_req_t r);
		int region;
		region = $urandom % 20;
		r.store = 1'($urandom);
		r.size = mem_size_e'($urandom % 4);
		r.is_signed = 1'($urandom);
		if (region < 16) r.addr = $urandom % 2048;
		else if (region < 18) r.addr = 32'h7f0 + $urandom % 32;
		else if (region < 19) r.addr = 32'h800 + $urandom % 32'h800;
		else r.addr = 32'h1000 + $urandom % 64;
		r.wdata = {$urandom, $urandom};
		r.tag = 6'(k);
	endtask

	// ==================================================
	// APB slave model
	// ==================================================

	always @(posedge clk) begin
		apb_beat_t exp;
		#1;
		if (rst) begin
			pready = 1'b0;
			pslverr = 1'b0;
		end else if (psel && !penable) begin
			if (exp_beats.size() == 0) report_failure("An APB beat started that was not expected");
			exp = exp_beats.pop_front();
			check_beat('{addr: paddr, strb: pstrb, wdata: pwdata}, exp);
			check_write(pwrite, exp_write);
			wait_left = $urandom_range(0, 3);
			pready = 1'b0;
			pslverr = 1'b0;
		end else if (psel && penable) begin
			if (wait_left > 0 || paddr >= 32'h1000) begin
				wait_left--;
				pready = 1'b0;
				prdata = {$urandom, $urandom};
			end else begin
				pready = 1'b1;
				pslverr = paddr[11];
				for (int l = 0; l < 8; l++) begin
					prdata[l * 8 +: 8] = mem[paddr[10:0] + l];
					if (!paddr[11] && pwrite && pstrb[l]) mem[paddr[10:0] + l] = pwdata[l * 8 +: 8];
				end
			end
		end else begin
			pready = 1'b0;
			pslverr = 1'b0;
		end
	end

	// Bounds the run and counts response pulses
	always @(negedge clk) begin
		cycles++;
		if (rsp_valid) rsp_count++;
		if (cycles > CYCLE_LIMIT) begin
			$display("TESTS FAILED");
			$fatal(1, "The run went past its limit of %0d cycles", CYCLE_LIMIT);
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	initial begin
		mem_req_t r;
		mem_rsp_t e;
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		prdata = '0;
		pready = 1'b0;
		pslverr = 1'b0;
		exp_write = 1'b0;
		cycles = 0;
		rsp_count = 0;
		wait_left = 0;
		void'($urandom(69));
		for (int i = 0; i < 2048; i++) begin
			mem[i] = fill_byte(i);
			ref_mem[i] = fill_byte(i);
		end
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
		if (!req_ready || psel || penable || rsp_valid) begin
			report_failure("Outputs after reset are not idle");
		end
		for (int k = 0; k < NUM_REQ; k++) begin
			make_request(k, r);
			predict(r, e);
			exp_write = r.store;
			while (!req_ready) begin
				@(posedge clk);
				#1;
			end
			req = r;
			req_valid = 1'b1;
			@(posedge clk);
			#1 req_valid = 1'b0;
			while (!rsp_valid) begin
				@(posedge clk);
				#1;
			end
			check_rsp(rsp, e);
			if (psel) report_failure("psel still high during the response");
			if (exp_beats.size() != 0) report_failure("Fewer APB beats than expected");
		end
		@(posedge clk);
		#1;
		if (rsp_count != NUM_REQ) report_failure("Response count differs from request count");
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== mem_seq_top.f ====
+incdir+.
mem_req_pkg.sv
apb_pkg.sv
access_if.sv
mem_agen.sv
load_merge.sv
wait_timer.sv
mem_seq_fsm.sv
mem_seq_top.sv
mem_seq_props.sv
mem_seq_tb.sv

// ==== mem_seq_top.sv ====
// Top level of the data-memory access sequencer. Plain request, response and
// APB master ports; inside, the FSM, timer, address generator and load merger.
`include "mem_seq_macros.svh"

module mem_seq_top import mem_req_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid_i,
	output logic                   req_ready_o,
	input  mem_req_t               req_i,
	output logic                   rsp_valid_o,
	output mem_rsp_t               rsp_o,
	output logic                   psel_o,
	output logic                   penable_o,
	output logic                   pwrite_o,
	output logic [`MEM_ADDR_W-1:0] paddr_o,
	output logic [`MEM_DATA_W-1:0] pwdata_o,
	output logic [`MEM_STRB_W-1:0] pstrb_o,
	input  logic [`MEM_DATA_W-1:0] prdata_i,
	input  logic                   pready_i,
	input  logic                   pslverr_i
);

	logic                   load;
	logic [`MEM_DATA_W-1:0] rdata;
	logic                   timer_run;
	logic                   timer_expired;

	// Lane plan of the access in flight
	access_if plan_if ();

	// Latches the plan in the acceptance cycle
	mem_agen u_agen (
		.clk    (clk),
		.rst    (rst),
		.req_i  (req_i),
		.load_i (load),
		.plan   (plan_if)
	);

	// Aligned and extended load data, valid in the last completing cycle
	load_merge u_merge (
		.clk      (clk),
		.rst      (rst),
		.prdata_i (prdata_i),
		.rdata_o  (rdata),
		.merge    (plan_if)
	);

	wait_timer u_timer (
		.clk       (clk),
		.rst       (rst),
		.run_i     (timer_run),
		.expired_o (timer_expired)
	);

	mem_seq_fsm u_fsm (
		.clk             (clk),
		.rst             (rst),
		.req_valid_i     (req_valid_i),
		.req_ready_o     (req_ready_o),
		.req_i           (req_i),
		.rsp_valid_o     (rsp_valid_o),
		.rsp_o           (rsp_o),
		.psel_o          (psel_o),
		.penable_o       (penable_o),
		.pwrite_o        (pwrite_o),
		.paddr_o         (paddr_o),
		.pwdata_o        (pwdata_o),
		.pstrb_o         (pstrb_o),
		.pready_i        (pready_i),
		.pslverr_i       (pslverr_i),
		.rdata_i         (rdata),
		.load_o          (load),
		.timer_run_o     (timer_run),
		.timer_expired_i (timer_expired),
		.plan            (plan_if)
	);

endmodule

// ==== wait_timer.sv ====
// Wait timer for the APB access phase. Counts while the FSM reports an access
// cycle and flags expiry on the last cycle the slave is allowed to stall.
`include "mem_seq_macros.svh"

module wait_timer import apb_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic run_i,
	output logic expired_o
);

	apb_wait_t cnt_q;

	// Cleared in every setup cycle and outside an access
	// Holds at the limit so the flag stays up until the FSM reacts
	always_ff @(posedge clk) begin
		if (rst || !run_i) begin
			cnt_q <= '0;
		end else if (!expired_o) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// The count lags by one, so the flag rises in the limit-th access cycle
	assign expired_o = run_i && (cnt_q == apb_wait_t'(`MEM_WAIT_LIMIT - 1));

endmodule
